// ==== source/periph_params.svh ====
// --------------------------------------
// Peripheral subsystem sizes, credits,
// address map and error word
// --------------------------------------
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Buffer depths and consumer credits
`define PERIPH_REQ_DEPTH    4
`define PERIPH_RSP_DEPTH    4
`define PERIPH_RSP_CREDITS  2

// Timer and interrupt counts
`define PERIPH_NUM_TIMERS   2
`define PERIPH_NUM_SOURCES  4
`define PERIPH_NUM_TARGETS  2
`define PERIPH_PRIO_WIDTH   3

`define PERIPH_ADDR_WIDTH   32
`define PERIPH_DATA_WIDTH   32

// Address map
`define PERIPH_PLIC_BASE    32'h0000_0000
`define PERIPH_TIMER_BASE   32'h0000_1000
`define PERIPH_ERR_RDATA    32'hDEAD_BEEF

`endif

// ==== source/periph_pkg.sv ====
// --------------------------------------
// Shared types of the register bus and
// the interrupt controller
// --------------------------------------
`default_nettype none

`include "periph_params.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`PERIPH_DATA_WIDTH-1:0] data_t;

    // Register bus request, 65 bits
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
    } reg_req_t;

    // Register bus response, 33 bits
    typedef struct packed {
        data_t rdata;
        logic  error;
    } reg_rsp_t;

    typedef logic [`PERIPH_NUM_SOURCES-1:0] irq_src_t;
    typedef logic [`PERIPH_NUM_TARGETS-1:0] irq_tgt_t;
    typedef logic [`PERIPH_PRIO_WIDTH-1:0]  prio_t;

    // Id 0 is reserved for no source
    typedef logic [$clog2(`PERIPH_NUM_SOURCES + 1)-1:0] src_id_t;

    typedef enum logic [1:0] {
        BLK_PLIC,
        BLK_TIMER,
        BLK_NONE
    } blk_sel_e;

endpackage

`default_nettype wire

// ==== source/credit_fifo.sv ====
// --------------------------------------
// Buffer stage with credit flow control
// toward its receiver
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter int  DEPTH       = 4,
    parameter int  OUT_CREDITS = 2,
    parameter type T           = logic
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic in_valid_i,
    input  T     in_data_i,
    output logic in_credit_o,
    output logic out_valid_o,
    output T     out_data_o,
    input  logic out_credit_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] credits_q;
    logic             pop;

    // Head leaves only while the receiver has room
    assign pop         = (count_q != '0) && (credits_q != '0);
    assign out_valid_o = pop;
    assign out_data_o  = mem[rd_ptr_q];
    assign in_credit_o = pop;

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            credits_q <= CRD_W'(OUT_CREDITS);
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q   <= count_q + CNT_W'(in_valid_i) - CNT_W'(pop);
            credits_q <= credits_q + CRD_W'(out_credit_i) - CRD_W'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== source/timer_bank.sv ====
// --------------------------------------
// Free-running timers with compare and
// overflow flags
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module timer_bank (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 acc_valid_i,
    input  periph_pkg::reg_req_t acc_req_i,
    output periph_pkg::data_t    rdata_o,
    output periph_pkg::irq_src_t irq_src_o
);
    import periph_pkg::*;

    localparam int NUM = `PERIPH_NUM_TIMERS;

    logic [7:0] tsel;
    logic [3:0] offset;
    data_t      rd_word [NUM];

    // 0x10 per timer, then the register offset
    assign tsel   = acc_req_i.addr[11:4];
    assign offset = acc_req_i.addr[3:0];

    for (genvar t = 0; t < NUM; t++) begin : gen_timer
        data_t cnt_q;
        data_t cmp_q;
        logic  en_q;
        logic  cmp_flag_q;
        logic  ovf_flag_q;
        logic  wr_sel;
        logic  tick;

        assign wr_sel = acc_valid_i && acc_req_i.write && (tsel == 8'(t));
        // A counter write takes this cycle's increment
        assign tick   = en_q && !(wr_sel && offset == 4'h0);

        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                cnt_q      <= '0;
                cmp_q      <= '0;
                en_q       <= 1'b0;
                cmp_flag_q <= 1'b0;
                ovf_flag_q <= 1'b0;
            end else begin
                if (wr_sel && offset == 4'h0) begin
                    cnt_q <= acc_req_i.wdata;
                end else if (tick) begin
                    cnt_q <= (cnt_q == cmp_q) ? '0 : cnt_q + 1'b1;
                end
                if (wr_sel && offset == 4'h8) begin
                    cmp_q <= acc_req_i.wdata;
                end
                if (wr_sel && offset == 4'h4) begin
                    en_q       <= acc_req_i.wdata[0];
                    cmp_flag_q <= 1'b0;
                    ovf_flag_q <= 1'b0;
                end else if (tick) begin
                    if (cnt_q == cmp_q) begin
                        cmp_flag_q <= 1'b1;
                    end else if (cnt_q == '1) begin
                        ovf_flag_q <= 1'b1;
                    end
                end
            end
        end

        assign rd_word[t] = (offset == 4'h0) ? cnt_q :
                            (offset == 4'h4) ? data_t'({ovf_flag_q, cmp_flag_q, en_q}) :
                            (offset == 4'h8) ? cmp_q : '0;

        // Source ids 1+2t and 2+2t
        assign irq_src_o[2*t]   = cmp_flag_q;
        assign irq_src_o[2*t+1] = ovf_flag_q;
    end

    always_comb begin
        rdata_o = '0;
        for (int t = 0; t < NUM; t++) begin
            if (tsel == 8'(t)) begin
                rdata_o = rd_word[t];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/plic_core.sv ====
// --------------------------------------
// Level-triggered interrupt controller
// with priorities and claim/complete
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module plic_core (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  periph_pkg::irq_src_t irq_src_i,
    input  logic                 acc_valid_i,
    input  periph_pkg::reg_req_t acc_req_i,
    output periph_pkg::data_t    rdata_o,
    output periph_pkg::irq_tgt_t irq_o
);
    import periph_pkg::*;

    localparam int NS = `PERIPH_NUM_SOURCES;
    localparam int NT = `PERIPH_NUM_TARGETS;

    prio_t       prio_q [NS];
    irq_src_t    enable_q [NT];
    prio_t       thresh_q [NT];
    irq_src_t    pending_q;
    irq_src_t    in_service_q;
    logic [11:0] offset;
    logic        wr_en;
    logic [NS-1:0] prio_sel;
    logic [NT-1:0] en_sel;
    logic [NT-1:0] thr_sel;
    logic [NT-1:0] claim_sel;
    src_id_t     cand_id [NT];
    prio_t       cand_prio [NT];
    irq_src_t    claim_mask;
    irq_src_t    complete_mask;

    assign offset = acc_req_i.addr[11:0];
    assign wr_en  = acc_valid_i && acc_req_i.write;

    // --------------------------------------
    // Register decode
    // --------------------------------------
    always_comb begin
        for (int s = 0; s < NS; s++) begin
            prio_sel[s] = (offset == 12'(4 * (s + 1)));
        end
        for (int t = 0; t < NT; t++) begin
            en_sel[t]    = (offset == 12'(12'h100 + 4 * t));
            thr_sel[t]   = (offset == 12'(12'h200 + 8 * t));
            claim_sel[t] = (offset == 12'(12'h204 + 8 * t));
        end
    end

    // Highest priority above threshold, ties to lowest id
    always_comb begin
        for (int t = 0; t < NT; t++) begin
            cand_id[t]   = '0;
            cand_prio[t] = thresh_q[t];
            for (int s = 0; s < NS; s++) begin
                if (pending_q[s] && enable_q[t][s] && prio_q[s] > cand_prio[t]) begin
                    cand_id[t]   = src_id_t'(s + 1);
                    cand_prio[t] = prio_q[s];
                end
            end
            irq_o[t] = (cand_id[t] != '0);
        end
    end

    // --------------------------------------
    // Read data, claim and complete
    // --------------------------------------
    always_comb begin
        rdata_o       = '0;
        claim_mask    = '0;
        complete_mask = '0;
        for (int s = 0; s < NS; s++) begin
            if (prio_sel[s]) begin
                rdata_o = data_t'(prio_q[s]);
            end
        end
        for (int t = 0; t < NT; t++) begin
            if (en_sel[t]) begin
                rdata_o = data_t'(enable_q[t]);
            end
            if (thr_sel[t]) begin
                rdata_o = data_t'(thresh_q[t]);
            end
            if (claim_sel[t]) begin
                rdata_o = data_t'(cand_id[t]);
                for (int s = 0; s < NS; s++) begin
                    if (acc_valid_i && !acc_req_i.write && cand_id[t] == src_id_t'(s + 1)) begin
                        claim_mask[s] = 1'b1;
                    end
                    if (wr_en && acc_req_i.wdata == data_t'(s + 1)) begin
                        complete_mask[s] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q       <= '{default: '0};
            enable_q     <= '{default: '0};
            thresh_q     <= '{default: '0};
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            for (int s = 0; s < NS; s++) begin
                if (wr_en && prio_sel[s]) begin
                    prio_q[s] <= acc_req_i.wdata[`PERIPH_PRIO_WIDTH-1:0];
                end
            end
            for (int t = 0; t < NT; t++) begin
                if (wr_en && en_sel[t]) begin
                    enable_q[t] <= acc_req_i.wdata[NS-1:0];
                end
                if (wr_en && thr_sel[t]) begin
                    thresh_q[t] <= acc_req_i.wdata[`PERIPH_PRIO_WIDTH-1:0];
                end
            end
            // Gateway blocks a source until its completion
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_access.sv ====
// --------------------------------------
// Address decode and register access,
// one cycle from request to response
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_access (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 acc_valid_i,
    input  periph_pkg::reg_req_t acc_req_i,
    output logic                 rsp_valid_o,
    output periph_pkg::reg_rsp_t rsp_o,
    output periph_pkg::irq_tgt_t irq_o
);
    import periph_pkg::*;

    localparam addr_t PLIC_BASE  = `PERIPH_PLIC_BASE;
    localparam addr_t TIMER_BASE = `PERIPH_TIMER_BASE;
    localparam data_t ERR_RDATA  = `PERIPH_ERR_RDATA;

    blk_sel_e blk_sel;
    logic     plic_valid;
    logic     timer_valid;
    data_t    plic_rdata;
    data_t    timer_rdata;
    irq_src_t irq_src;
    reg_rsp_t rsp_d;

    // Bits 15..12 pick the block
    always_comb begin
        if (acc_req_i.addr[15:12] == PLIC_BASE[15:12]) begin
            blk_sel = BLK_PLIC;
        end else if (acc_req_i.addr[15:12] == TIMER_BASE[15:12]) begin
            blk_sel = BLK_TIMER;
        end else begin
            blk_sel = BLK_NONE;
        end
    end

    assign plic_valid  = acc_valid_i && (blk_sel == BLK_PLIC);
    assign timer_valid = acc_valid_i && (blk_sel == BLK_TIMER);

    timer_bank i_timer_bank (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .acc_valid_i ( timer_valid ),
        .acc_req_i   ( acc_req_i   ),
        .rdata_o     ( timer_rdata ),
        .irq_src_o   ( irq_src     )
    );

    plic_core i_plic_core (
        .clk_i       ( clk_i      ),
        .arst_n_i    ( arst_n_i   ),
        .irq_src_i   ( irq_src    ),
        .acc_valid_i ( plic_valid ),
        .acc_req_i   ( acc_req_i  ),
        .rdata_o     ( plic_rdata ),
        .irq_o       ( irq_o      )
    );

    // Writes to a mapped block answer with a zero word
    always_comb begin
        rsp_d.error = 1'b0;
        rsp_d.rdata = '0;
        case (blk_sel)
            BLK_PLIC:  rsp_d.rdata = acc_req_i.write ? '0 : plic_rdata;
            BLK_TIMER: rsp_d.rdata = acc_req_i.write ? '0 : timer_rdata;
            default: begin
                rsp_d.error = 1'b1;
                rsp_d.rdata = ERR_RDATA;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= acc_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (acc_valid_i) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_top.sv ====
// --------------------------------------
// Peripheral subsystem: request buffer,
// register access, response buffer
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 req_valid_i,
    input  periph_pkg::reg_req_t req_i,
    output logic                 req_credit_o,
    output logic                 rsp_valid_o,
    output periph_pkg::reg_rsp_t rsp_o,
    input  logic                 rsp_credit_i,
    output periph_pkg::irq_tgt_t irq_o
);
    import periph_pkg::*;

    logic     acc_valid;
    reg_req_t acc_req;
    logic     acc_rsp_valid;
    reg_rsp_t acc_rsp;
    // Response slot freed, one more request may enter access
    logic     rsp_buf_credit;

    credit_fifo #(
        .DEPTH       ( `PERIPH_REQ_DEPTH ),
        .OUT_CREDITS ( `PERIPH_RSP_DEPTH ),
        .T           ( reg_req_t         )
    ) i_req_buf (
        .clk_i        ( clk_i          ),
        .arst_n_i     ( arst_n_i       ),
        .in_valid_i   ( req_valid_i    ),
        .in_data_i    ( req_i          ),
        .in_credit_o  ( req_credit_o   ),
        .out_valid_o  ( acc_valid      ),
        .out_data_o   ( acc_req        ),
        .out_credit_i ( rsp_buf_credit )
    );

    periph_access i_access (
        .clk_i       ( clk_i         ),
        .arst_n_i    ( arst_n_i      ),
        .acc_valid_i ( acc_valid     ),
        .acc_req_i   ( acc_req       ),
        .rsp_valid_o ( acc_rsp_valid ),
        .rsp_o       ( acc_rsp       ),
        .irq_o       ( irq_o         )
    );

    credit_fifo #(
        .DEPTH       ( `PERIPH_RSP_DEPTH   ),
        .OUT_CREDITS ( `PERIPH_RSP_CREDITS ),
        .T           ( reg_rsp_t           )
    ) i_rsp_buf (
        .clk_i        ( clk_i          ),
        .arst_n_i     ( arst_n_i       ),
        .in_valid_i   ( acc_rsp_valid  ),
        .in_data_i    ( acc_rsp        ),
        .in_credit_o  ( rsp_buf_credit ),
        .out_valid_o  ( rsp_valid_o    ),
        .out_data_o   ( rsp_o          ),
        .out_credit_i ( rsp_credit_i   )
    );

endmodule

`default_nettype wire

// ==== sim/periph_checker.sv ====
// --------------------------------------
// In-order response checker against
// queued expectations
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 exp_push_i,
    input  periph_pkg::addr_t    exp_addr_i,
    input  periph_pkg::reg_rsp_t exp_rsp_i,
    input  logic                 req_credit_i,
    input  logic                 rsp_valid_i,
    input  periph_pkg::reg_rsp_t rsp_i,
    input  periph_pkg::irq_tgt_t irq_i,
    output int                   checked_o,
    output int                   errors_o
);
    import periph_pkg::*;

    typedef struct packed {
        addr_t    addr;
        reg_rsp_t rsp;
    } exp_entry_t;

    exp_entry_t exp_q [$];
    exp_entry_t entry;
    exp_entry_t head;
    int         checked  = 0;
    int         errors   = 0;
    int         pushed   = 0;
    int         credited = 0;

    assign checked_o = checked;
    assign errors_o  = errors;

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            // Outputs stay quiet in reset
            if (req_credit_i || rsp_valid_i || irq_i != '0) begin
                $display("error at %0t: DUT outputs not low during reset", $time);
                errors = errors + 1;
            end
        end else begin
            // A request credit only follows a request already buffered
            if (req_credit_i) begin
                if (credited >= pushed) begin
                    $display("error at %0t: request credit with no request buffered",
                             $time);
                    errors = errors + 1;
                end
                credited = credited + 1;
            end
            if (exp_push_i) begin
                entry.addr = exp_addr_i;
                entry.rsp  = exp_rsp_i;
                exp_q.push_back(entry);
                pushed = pushed + 1;
            end
            if (rsp_valid_i) begin
                checked = checked + 1;
                if (exp_q.size() == 0) begin
                    $display("error at %0t: response %0d arrived with no request pending",
                             $time, checked);
                    errors = errors + 1;
                end else begin
                    head = exp_q.pop_front();
                    if (head.rsp !== rsp_i) begin
                        $display("error at %0t: test %0d addr %h got %h/%b, expected %h/%b",
                                 $time, checked, head.addr, rsp_i.rdata, rsp_i.error,
                                 head.rsp.rdata, head.rsp.error);
                        errors = errors + 1;
                    end else begin
                        $display("test %0d addr %h rdata %h error %b ok",
                                 checked, head.addr, rsp_i.rdata, rsp_i.error);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/periph_tb.sv ====
// --------------------------------------
// Testbench for the peripheral subsystem
// with operations read from a data file
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_tb;
    import periph_pkg::*;

    localparam int MAX_OPS   = 64;
    localparam int TIMEOUT   = 2000;
    localparam int REQ_DEPTH = `PERIPH_REQ_DEPTH;

    logic        clk          = 1'b0;
    logic        arst_n;
    logic        req_valid;
    reg_req_t    req;
    logic        req_credit;
    logic        rsp_valid;
    reg_rsp_t    rsp;
    logic        rsp_credit   = 1'b0;
    irq_tgt_t    irq;
    logic        exp_push;
    addr_t       exp_addr;
    reg_rsp_t    exp_rsp;
    int          checked;
    int          errors;

    // Five words per line for op, addr, data, expected rdata and error
    logic [31:0] stim [MAX_OPS*5];
    integer      seed         = 32'he18f_a43c;
    int          sent_cnt;
    int          req_crd_cnt  = 0;
    int          rsp_seen_cnt = 0;
    int          rsp_crd_cnt  = 0;
    int          crd_delay    = 0;
    int          max_delay;
    logic        timed_out;

    always #5 clk = ~clk;

    periph_top periph_top_i (
        .clk_i        ( clk        ),
        .arst_n_i     ( arst_n     ),
        .req_valid_i  ( req_valid  ),
        .req_i        ( req        ),
        .req_credit_o ( req_credit ),
        .rsp_valid_o  ( rsp_valid  ),
        .rsp_o        ( rsp        ),
        .rsp_credit_i ( rsp_credit ),
        .irq_o        ( irq        )
    );

    periph_checker checker_i (
        .clk_i        ( clk        ),
        .arst_n_i     ( arst_n     ),
        .exp_push_i   ( exp_push   ),
        .exp_addr_i   ( exp_addr   ),
        .exp_rsp_i    ( exp_rsp    ),
        .req_credit_i ( req_credit ),
        .rsp_valid_i  ( rsp_valid  ),
        .rsp_i        ( rsp        ),
        .irq_i        ( irq        ),
        .checked_o    ( checked    ),
        .errors_o     ( errors     )
    );

    // --------------------------------------
    // Credit bookkeeping
    // --------------------------------------
    always @(posedge clk) begin
        if (req_credit) begin
            req_crd_cnt <= req_crd_cnt + 1;
        end
        if (rsp_valid) begin
            rsp_seen_cnt <= rsp_seen_cnt + 1;
        end
    end

    // One response credit back per response after a random pause
    always @(negedge clk) begin
        rsp_credit = 1'b0;
        if (rsp_seen_cnt > rsp_crd_cnt) begin
            if (crd_delay == 0) begin
                rsp_credit  = 1'b1;
                rsp_crd_cnt = rsp_crd_cnt + 1;
                crd_delay   = $unsigned($random(seed)) % (max_delay + 1);
            end else begin
                crd_delay = crd_delay - 1;
            end
        end
    end

    task automatic send_req(input logic wr, input addr_t addr, input data_t wdata,
                            input data_t exp_rdata, input logic exp_err);
        int waited;
        waited = 0;
        while (sent_cnt - req_crd_cnt >= REQ_DEPTH && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (sent_cnt - req_crd_cnt >= REQ_DEPTH) begin
            $display("timeout: no request credit came back by %0t", $time);
            timed_out = 1'b1;
        end else begin
            req_valid     = 1'b1;
            req.addr      = addr;
            req.write     = wr;
            req.wdata     = wdata;
            exp_push      = 1'b1;
            exp_addr      = addr;
            exp_rsp.rdata = exp_rdata;
            exp_rsp.error = exp_err;
            sent_cnt++;
            @(negedge clk);
            req_valid = 1'b0;
            exp_push  = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (checked < sent_cnt && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (checked < sent_cnt) begin
            $display("timeout: %0d responses still missing at %0t", sent_cnt - checked, $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_irq(input int tgt, input logic level);
        int       waited;
        irq_tgt_t mask;
        waited = 0;
        mask   = irq_tgt_t'(1) << tgt;
        while (((irq & mask) != '0) != level && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (((irq & mask) != '0) != level) begin
            $display("timeout: irq_o[%0d] never went to %0d by %0t", tgt, level, $time);
            timed_out = 1'b1;
        end else begin
            $display("irq_o[%0d] at %0d after %0d cycles", tgt, level, waited);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // --------------------------------------
    // Stimulus
    // --------------------------------------
    initial begin
        int          op_idx;
        int          base;
        logic [31:0] op;
        logic        done;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        exp_push  = 1'b0;
        exp_addr  = '0;
        exp_rsp   = '0;
        sent_cnt  = 0;
        max_delay = 3;
        timed_out = 1'b0;
        done      = 1'b0;
        op_idx    = 0;
        $readmemh("sim/periph_input.txt", stim);
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        while (!done && !timed_out && op_idx < MAX_OPS) begin
            base = op_idx * 5;
            op   = stim[base];
            case (op)
                32'd1: send_req(1'b1, stim[base+1], stim[base+2], stim[base+3],
                                stim[base+4][0]);
                32'd2: send_req(1'b0, stim[base+1], stim[base+2], stim[base+3],
                                stim[base+4][0]);
                32'd3: begin
                    wait_drained();
                    if (!timed_out) begin
                        wait_irq(stim[base+1], 1'b1);
                    end
                end
                32'd4: begin
                    wait_drained();
                    if (!timed_out) begin
                        wait_irq(stim[base+1], 1'b0);
                    end
                end
                32'd5: max_delay = stim[base+2];
                32'd6: begin
                    wait_drained();
                    idle_cycles(stim[base+2]);
                end
                default: done = 1'b1;
            endcase
            op_idx++;
        end

        if (!timed_out) begin
            wait_drained();
        end
        // Late extra responses would show up here
        idle_cycles(20);
        if (sent_cnt == 0) begin
            $display("no operations were read from the data file");
        end
        if (req_crd_cnt != sent_cnt) begin
            $display("request credits came back %0d times for %0d requests",
                     req_crd_cnt, sent_cnt);
        end
        $display("sent %0d requests, checked %0d responses, %0d errors",
                 sent_cnt, checked, errors);
        if (timed_out || errors != 0 || checked != sent_cnt || sent_cnt == 0 ||
            req_crd_cnt != sent_cnt) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/periph_input.txt ====
// op addr data exp_rdata exp_err, hex; op 1 write, 2 read, 3/4 wait irq bit addr high/low,
// 5 max credit delay in data, 6 idle data cycles, 0 end
// Read-back
1 00000004 00000005 00000000 0
2 00000004 00000000 00000005 0
1 0000000C 00000003 00000000 0
2 0000000C 00000000 00000003 0
1 00000100 00000005 00000000 0
2 00000100 00000000 00000005 0
1 00000200 00000001 00000000 0
2 00000200 00000000 00000001 0
1 00001008 00000008 00000000 0
2 00001008 00000000 00000008 0
// Unmapped block, state unchanged
1 00002004 00000007 DEADBEEF 1
2 00003004 00000000 DEADBEEF 1
2 00000004 00000000 00000005 0
// Timer 0 compare, id 1 on target 0
1 00001004 00000001 00000000 0
3 00000000 00000000 00000000 0
2 00000204 00000000 00000001 0
1 00001004 00000000 00000000 0
1 00000204 00000001 00000000 0
4 00000000 00000000 00000000 0
// Ids 1 and 3 pending, then threshold 5
1 00001018 00000004 00000000 0
1 00001004 00000001 00000000 0
1 00001014 00000001 00000000 0
6 00000000 00000028 00000000 0
2 00000204 00000000 00000001 0
1 00000200 00000005 00000000 0
4 00000000 00000000 00000000 0
2 00000204 00000000 00000000 0
1 00001004 00000000 00000000 0
1 00001014 00000000 00000000 0
1 00000204 00000001 00000000 0
// Timer 1 overflow, id 4 on target 1
1 00000010 00000002 00000000 0
1 00000104 00000008 00000000 0
1 00001010 FFFFFFFE 00000000 0
1 00001014 00000001 00000000 0
3 00000001 00000000 00000000 0
2 0000020C 00000000 00000004 0
1 00001014 00000000 00000000 0
1 0000020C 00000004 00000000 0
4 00000001 00000000 00000000 0
// Burst of reads under slow response credits
5 00000000 0000000C 00000000 0
2 00000004 00000000 00000005 0
2 0000000C 00000000 00000003 0
2 00000010 00000000 00000002 0
2 00000100 00000000 00000005 0
2 00000104 00000000 00000008 0
2 00000200 00000000 00000005 0
2 00000208 00000000 00000000 0
2 00001018 00000000 00000004 0
2 00002008 00000000 DEADBEEF 1
0 00000000 00000000 00000000 0

// ==== list.f ====
+incdir+source
source/periph_pkg.sv
source/credit_fifo.sv
source/timer_bank.sv
source/plic_core.sv
source/periph_access.sv
source/periph_top.sv
sim/periph_checker.sv
sim/periph_tb.sv

// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
RTL_TOP   ?= periph_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, not the exit code of the simulator
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass line missing from $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
